//--- vlog.f
common/turfio_pkg.sv
verilog/tio_id_ctrl.sv
verilog/turfio_intercon.sv
uart/uart_route.sv
uart/uart_retime.sv
verilog/turfio_top.sv
sim/tb_turfio.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TURFIO testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps -f vlog.f --top-module tb_turfio \
    -o tb_turfio_sim \
    && { ./obj_dir/tb_turfio_sim > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Simulation failed" sim.log \
    && grep -q "Simulation completed successfully" sim.log \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }

//--- sim/tb_turfio.sv
`timescale 1ns/10ps
module tb_turfio;

    // UART lines driven into the DUT and probed on its outputs
    typedef enum int {src_dbg_rx, src_turf_rx, src_surf_tx} uart_src_t;
    typedef enum int {line_surf_rx, line_dbg_tx, line_turf_tx} uart_sink_t;

    logic                               init_clk;
    logic                               rst_n_i;
    logic                               host_req_i;
    logic                               host_we_i;
    logic [turfio_pkg::addr_bits-1:0]   host_addr_i;
    logic [turfio_pkg::data_bits-1:0]   host_wdata_i;
    logic                               host_ack_o;
    logic [turfio_pkg::data_bits-1:0]   host_rdata_o;
    logic                               dbg_rx_i;
    logic                               dbg_tx_o;
    logic                               turf_rx_i;
    logic                               turf_tx_o;
    logic                               tctrl_b_i;
    logic                               surf_tx_i;
    logic                               surf_rx_o;
    logic                               i2c_rdy_i;
    logic [1:0]                         conf_i;
    logic                               enable_crate_o;
    logic                               enable_3v3_o;

    // Reference copies of the writable registers
    logic [3:0]                         model_ctrl;
    logic [31:0]                        model_scratch;

    turfio_top uut (.*);

    always #10 init_clk = ~init_clk;

    ////////////////////////////////////////////////////////////////////////////
    // Checks and host access
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // One cycle on, inputs change 1 ns after the edge
    task automatic step();
        @(posedge init_clk);
        #1;
    endtask

    // Space, module, word index, byte offset zero
    function automatic logic [turfio_pkg::addr_bits-1:0] make_addr(input logic [2:0] space,
            input logic [9:0] mod_sel, input logic [9:0] index);
        return {space, mod_sel, index, 2'b00};
    endfunction

    function automatic logic [turfio_pkg::addr_bits-1:0] reg_addr(input logic [9:0] index);
        return make_addr(3'd0, 10'd0, index);
    endfunction

    task automatic host_access(input logic we, input logic [turfio_pkg::addr_bits-1:0] addr,
            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        step();
        host_req_i = 1'b1;
        host_we_i = we;
        host_addr_i = addr;
        host_wdata_i = wdata;
        waited = 0;
        while (!host_ack_o && waited < 16) begin
            step();
            waited++;
        end
        if (!host_ack_o) report_failure("host ack never rose after req");
        // Sampled at N, ack from N+1
        check_value("host_ack_o latency", waited, 2);
        rdata = host_rdata_o;
        host_req_i = 1'b0;
        waited = 0;
        while (host_ack_o && waited < 16) begin
            step();
            waited++;
        end
        if (host_ack_o) report_failure("host ack stayed high after req dropped");
    endtask

    task automatic reg_write(input logic [turfio_pkg::addr_bits-1:0] addr, input logic [31:0] data);
        logic [31:0] unused_rdata;
        host_access(1'b1, addr, data, unused_rdata);
    endtask

    task automatic check_read(input logic [turfio_pkg::addr_bits-1:0] addr,
            input logic [31:0] exp, input string name);
        logic [31:0] rdata;
        host_access(1'b0, addr, 32'd0, rdata);
        check_value(name, rdata, exp);
    endtask

    task automatic check_enables();
        check_value("enable_crate_o", 32'(enable_crate_o), 32'(model_ctrl[2]));
        check_value("enable_3v3_o", 32'(enable_3v3_o), 32'(model_ctrl[3]));
    endtask

    // Only the low 4 bits are kept
    task automatic write_ctrl(input logic [31:0] wdata);
        reg_write(reg_addr(turfio_pkg::reg_ctrl), wdata);
        model_ctrl = wdata[3:0];
        check_enables();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // UART lines
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_line(input uart_src_t src, input logic level);
        case (src)
            src_dbg_rx: dbg_rx_i = level;
            src_turf_rx: turf_rx_i = level;
            default: surf_tx_i = level;
        endcase
    endtask

    function automatic logic read_line(input uart_sink_t sink);
        case (sink)
            line_surf_rx: return surf_rx_o;
            line_dbg_tx: return dbg_tx_o;
            default: return turf_tx_o;
        endcase
    endfunction

    // Port name of a probed line
    function automatic string line_name(input uart_sink_t sink);
        case (sink)
            line_surf_rx: return "surf_rx_o";
            line_dbg_tx: return "dbg_tx_o";
            default: return "turf_tx_o";
        endcase
    endfunction

    task automatic uart_send(input uart_src_t src, input logic [7:0] data);
        logic [9:0] frame;
        int i;
        // Start low, LSB first, stop high
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < turfio_pkg::uart_frame_bits; i++) begin
            step();
            set_line(src, frame[i]);
            repeat (turfio_pkg::uart_baud_period - 1) @(posedge init_clk);
        end
    endtask

    task automatic uart_receive(input uart_sink_t sink, output logic [7:0] data);
        int waited;
        int i;
        waited = 0;
        @(negedge init_clk);
        while (read_line(sink) && waited < 4 * turfio_pkg::uart_baud_period) begin
            @(negedge init_clk);
            waited++;
        end
        if (read_line(sink)) report_failure("no start bit seen on the UART line");
        // Half a bit on, then mid-bit samples
        repeat (turfio_pkg::uart_baud_period / 2) @(negedge init_clk);
        check_value({line_name(sink), " start bit"}, 32'(read_line(sink)), 32'd0);
        for (i = 0; i < 8; i++) begin
            repeat (turfio_pkg::uart_baud_period) @(negedge init_clk);
            data[i] = read_line(sink);
        end
        repeat (turfio_pkg::uart_baud_period) @(negedge init_clk);
        check_value({line_name(sink), " stop bit"}, 32'(read_line(sink)), 32'd1);
    endtask

    task automatic watch_high(input uart_sink_t sink, input int cycles);
        repeat (cycles) begin
            @(negedge init_clk);
            check_value(line_name(sink), 32'(read_line(sink)), 32'd1);
        end
    endtask

    // Random byte in, same byte out, a third line idle
    task automatic uart_transfer(input uart_src_t src, input uart_sink_t sink,
            input uart_sink_t quiet);
        logic [7:0] sent;
        logic [7:0] got;
        sent = 8'($urandom);
        fork
            uart_send(src, sent);
            uart_receive(sink, got);
            watch_high(quiet, (turfio_pkg::uart_frame_bits + 1) * turfio_pkg::uart_baud_period);
        join
        check_value(line_name(sink), 32'(got), 32'(sent));
    endtask

    task automatic uart_blocked(input uart_src_t src, input uart_sink_t sink);
        fork
            uart_send(src, 8'($urandom));
            watch_high(sink, turfio_pkg::uart_frame_bits * turfio_pkg::uart_baud_period);
        join
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned seed_val;
        int n;
        logic [31:0] wdata;
        logic [2:0] space;
        logic [9:0] mod_sel;
        logic [turfio_pkg::addr_bits-1:0] addr;
        init_clk = 1'b0;
        rst_n_i = 1'b0;
        host_req_i = 1'b0;
        host_we_i = 1'b0;
        host_addr_i = '0;
        host_wdata_i = '0;
        // UART lines idle high
        dbg_rx_i = 1'b1;
        turf_rx_i = 1'b1;
        surf_tx_i = 1'b1;
        tctrl_b_i = 1'b0;
        i2c_rdy_i = 1'b0;
        conf_i = 2'b00;
        model_ctrl = '0;
        model_scratch = '0;
        seed_val = $urandom(94);
        repeat (2) @(posedge init_clk);
        #1;
        rst_n_i = 1'b1;

        // Identification, ASCII TFIO
        check_read(reg_addr(turfio_pkg::reg_ident), 32'h5446_494F, "host_rdata_o ident");
        check_read(reg_addr(turfio_pkg::reg_version), turfio_pkg::date_version,
                   "host_rdata_o version");
        check_enables();

        // Random register traffic against the model
        for (n = 0; n < 60; n++) begin
            wdata = $urandom;
            case ($urandom_range(0, 4))
                0: begin
                    reg_write(reg_addr(turfio_pkg::reg_scratch), wdata);
                    model_scratch = wdata;
                end
                1: write_ctrl(wdata);
                2: check_read(reg_addr(turfio_pkg::reg_scratch), model_scratch,
                              "host_rdata_o scratch");
                3: check_read(reg_addr(turfio_pkg::reg_ctrl), {28'd0, model_ctrl},
                              "host_rdata_o ctrl");
                default: begin
                    step();
                    i2c_rdy_i = wdata[0];
                    conf_i = wdata[2:1];
                    check_read(reg_addr(turfio_pkg::reg_status),
                               {29'd0, wdata[2:1], wdata[0]}, "host_rdata_o status");
                end
            endcase
        end

        // Unmapped spaces and modules
        for (n = 0; n < 30; n++) begin
            space = 3'($urandom);
            mod_sel = 10'($urandom);
            if (space == 3'd0 && mod_sel == 10'd0) mod_sel = 10'd1;
            addr = make_addr(space, mod_sel, 10'($urandom_range(0, 7)));
            if (n % 2 == 0) reg_write(addr, $urandom);
            else check_read(addr, 32'd0, "host_rdata_o unmapped");
        end
        check_read(reg_addr(10'($urandom_range(5, 1023))), 32'd0, "host_rdata_o unused index");
        check_read(reg_addr(turfio_pkg::reg_scratch), model_scratch, "host_rdata_o scratch");
        check_read(reg_addr(turfio_pkg::reg_ctrl), {28'd0, model_ctrl}, "host_rdata_o ctrl");
        check_enables();

        // Local mode, bridge on
        write_ctrl(32'h0000_0003);
        for (n = 0; n < 3; n++) uart_transfer(src_dbg_rx, line_surf_rx, line_turf_tx);
        for (n = 0; n < 3; n++) uart_transfer(src_surf_tx, line_dbg_tx, line_turf_tx);

        // TURF path, bridge on
        write_ctrl(32'h0000_0002);
        for (n = 0; n < 3; n++) uart_transfer(src_turf_rx, line_surf_rx, line_dbg_tx);
        for (n = 0; n < 3; n++) uart_transfer(src_surf_tx, line_turf_tx, line_dbg_tx);

        // TURF lines carry I2C
        step();
        tctrl_b_i = 1'b1;
        uart_blocked(src_turf_rx, line_surf_rx);
        step();
        tctrl_b_i = 1'b0;
        // Bridge off in both directions
        write_ctrl(32'h0000_0000);
        uart_blocked(src_turf_rx, line_surf_rx);
        uart_blocked(src_surf_tx, line_turf_tx);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog/turfio_top.sv
`timescale 1ns/10ps
module turfio_top (
    input  logic                                init_clk,
    input  logic                                rst_n_i,
    // Host register port
    input  logic                                host_req_i,
    input  logic                                host_we_i,
    input  logic [turfio_pkg::addr_bits-1:0]    host_addr_i,
    input  logic [turfio_pkg::data_bits-1:0]    host_wdata_i,
    output logic                                host_ack_o,
    output logic [turfio_pkg::data_bits-1:0]    host_rdata_o,
    // Housekeeping UART lines
    input  logic                                dbg_rx_i,
    output logic                                dbg_tx_o,
    input  logic                                turf_rx_i,
    output logic                                turf_tx_o,
    input  logic                                tctrl_b_i,
    input  logic                                surf_tx_i,
    output logic                                surf_rx_o,
    // Board status and enables
    input  logic                                i2c_rdy_i,
    input  logic [1:0]                          conf_i,
    output logic                                enable_crate_o,
    output logic                                enable_3v3_o
);

    // Register strobe path
    logic                               reg_sel;
    logic                               reg_we;
    logic [turfio_pkg::reg_bits-1:0]    reg_index;
    logic [turfio_pkg::data_bits-1:0]   reg_wdata;
    logic [turfio_pkg::data_bits-1:0]   reg_rdata;

    // UART control from the control register
    logic                               hsk_local;
    logic                               cratebridge_en;
    // Crate line after retiming
    logic                               crate_rx;

    turfio_intercon u_intercon (
        .init_clk     (init_clk),
        .rst_n_i      (rst_n_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .reg_sel_o    (reg_sel),
        .reg_we_o     (reg_we),
        .reg_index_o  (reg_index),
        .reg_wdata_o  (reg_wdata),
        .reg_rdata_i  (reg_rdata)
    );

    tio_id_ctrl u_id_ctrl (
        .init_clk         (init_clk),
        .rst_n_i          (rst_n_i),
        .reg_sel_i        (reg_sel),
        .reg_we_i         (reg_we),
        .reg_index_i      (reg_index),
        .reg_wdata_i      (reg_wdata),
        .reg_rdata_o      (reg_rdata),
        .i2c_rdy_i        (i2c_rdy_i),
        .conf_i           (conf_i),
        .hsk_local_o      (hsk_local),
        .cratebridge_en_o (cratebridge_en),
        .enable_crate_o   (enable_crate_o),
        .enable_3v3_o     (enable_3v3_o)
    );

    uart_route u_route (
        .dbg_rx_i         (dbg_rx_i),
        .turf_rx_i        (turf_rx_i),
        .tctrl_b_i        (tctrl_b_i),
        .hsk_local_i      (hsk_local),
        .cratebridge_en_i (cratebridge_en),
        .crate_rx_i       (crate_rx),
        .dbg_tx_o         (dbg_tx_o),
        .turf_tx_o        (turf_tx_o),
        .surf_rx_o        (surf_rx_o)
    );

    uart_retime u_retime (
        .init_clk         (init_clk),
        .rst_n_i          (rst_n_i),
        .cratebridge_en_i (cratebridge_en),
        .surf_tx_i        (surf_tx_i),
        .rx_retimed_o     (crate_rx)
    );

endmodule

//--- uart/uart_retime.sv
`timescale 1ns/10ps
module uart_retime (
    input  logic init_clk,
    input  logic rst_n_i,
    // Crate bridge enable, output idles while low
    input  logic cratebridge_en_i,
    // Open-drain SURF TX, slow rising edges
    input  logic surf_tx_i,
    output logic rx_retimed_o
);

    logic [1:0]                             sync_q;
    // Last synchronized level for edge detect
    logic                                   rx_prev_q;
    logic                                   start_edge;
    // Inside a frame
    logic                                   busy_q;
    logic [turfio_pkg::uart_cnt_bits-1:0]   baud_cnt_q;
    logic [turfio_pkg::uart_bit_bits-1:0]   bit_cnt_q;
    logic                                   sample_now;

    ////////////////////////////////////////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            // Line idles high
            sync_q <= 2'b11;
            rx_prev_q <= 1'b1;
        end else begin
            sync_q <= {sync_q[0], surf_tx_i};
            rx_prev_q <= sync_q[1];
        end
    end

    // Falling edge marks the start bit
    assign start_edge = rx_prev_q && !sync_q[1];

    // Sample point within each bit
    assign sample_now = busy_q && (baud_cnt_q == turfio_pkg::uart_sample_cnt);

    ////////////////////////////////////////////////////////////////////////////
    // Bit timing and regeneration
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            baud_cnt_q <= '0;
            bit_cnt_q <= '0;
            rx_retimed_o <= 1'b1;
        end else if (!cratebridge_en_i) begin
            // Bridge off, abort any frame and idle
            busy_q <= 1'b0;
            baud_cnt_q <= '0;
            bit_cnt_q <= '0;
            rx_retimed_o <= 1'b1;
        end else if (!busy_q) begin
            // Hunt for a start edge
            baud_cnt_q <= '0;
            bit_cnt_q <= '0;
            if (start_edge) begin
                busy_q <= 1'b1;
            end
        end else begin
            // Free-running bit period
            if (baud_cnt_q == turfio_pkg::uart_period_last) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            // Held until the next sample
            if (sample_now) begin
                rx_retimed_o <= sync_q[1];
                // Stop bit done, back to hunting
                if (bit_cnt_q == turfio_pkg::uart_last_bit) begin
                    busy_q <= 1'b0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

//--- uart/uart_route.sv
`timescale 1ns/10ps
module uart_route (
    // Debug UART from the USB bridge
    input  logic dbg_rx_i,
    // TURF serial input
    input  logic turf_rx_i,
    // High selects remote I2C on the TURF lines
    input  logic tctrl_b_i,
    // Control register bits
    input  logic hsk_local_i,
    input  logic cratebridge_en_i,
    // Crate line after retiming
    input  logic crate_rx_i,
    output logic dbg_tx_o,
    output logic turf_tx_o,
    output logic surf_rx_o
);

    // TURF input after the TCTRL_B qualifier
    logic turf_rx_valid;
    // Merged data toward the crate
    logic to_crate;

    ////////////////////////////////////////////////////////////////////////////
    // Source selection toward the crate
    ////////////////////////////////////////////////////////////////////////////

    // Idle high when TURF lines carry I2C
    assign turf_rx_valid = tctrl_b_i ? 1'b1 : turf_rx_i;

    // Local mode takes debug RX, else TURF
    assign to_crate = hsk_local_i ? dbg_rx_i : turf_rx_valid;

    // Nothing reaches the SURFs without the bridge enable
    assign surf_rx_o = cratebridge_en_i ? to_crate : 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Crate responses
    ////////////////////////////////////////////////////////////////////////////

    // Crate answers go back to whichever side is talking
    assign dbg_tx_o = hsk_local_i ? crate_rx_i : 1'b1;
    assign turf_tx_o = hsk_local_i ? 1'b1 : crate_rx_i;

endmodule

//--- verilog/turfio_intercon.sv
`timescale 1ns/10ps
module turfio_intercon (
    input  logic                                init_clk,
    input  logic                                rst_n_i,
    // Four-phase host side
    input  logic                                host_req_i,
    input  logic                                host_we_i,
    input  logic [turfio_pkg::addr_bits-1:0]    host_addr_i,
    input  logic [turfio_pkg::data_bits-1:0]    host_wdata_i,
    output logic                                host_ack_o,
    output logic [turfio_pkg::data_bits-1:0]    host_rdata_o,
    // Module 0 register side
    output logic                                reg_sel_o,
    output logic                                reg_we_o,
    output logic [turfio_pkg::reg_bits-1:0]     reg_index_o,
    output logic [turfio_pkg::data_bits-1:0]    reg_wdata_o,
    input  logic [turfio_pkg::data_bits-1:0]    reg_rdata_i
);

    // Idle, one access cycle, then wait for req to drop
    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_wait
    } state_t;

    state_t                                 state_q;
    logic [turfio_pkg::space_bits-1:0]      space_field;
    logic [turfio_pkg::module_bits-1:0]     module_field;
    logic                                   reg_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    assign space_field = host_addr_i[turfio_pkg::space_lsb +: turfio_pkg::space_bits];
    assign module_field = host_addr_i[turfio_pkg::module_lsb +: turfio_pkg::module_bits];

    // Only TURFIO space, module 0 is mapped
    assign reg_hit = (space_field == '0) && (module_field == '0);

    // Host fields are stable while req is high
    assign reg_we_o = host_we_i;
    assign reg_index_o = host_addr_i[turfio_pkg::reg_lsb +: turfio_pkg::reg_bits];
    assign reg_wdata_o = host_wdata_i;

    // One-cycle strobe in the access state
    // Unmapped accesses complete without it
    assign reg_sel_o = (state_q == st_access) && reg_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
            host_ack_o <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    // Request seen, access on the next edge
                    if (host_req_i) begin
                        state_q <= st_access;
                    end
                end
                st_access: begin
                    host_ack_o <= 1'b1;
                    state_q <= st_wait;
                end
                st_wait: begin
                    // Ack holds until the host lets go
                    if (!host_req_i) begin
                        host_ack_o <= 1'b0;
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // Read data lands together with ack
    // Unmapped space reads as zero
    always_ff @(posedge init_clk) begin
        if (state_q == st_access) begin
            host_rdata_o <= reg_hit ? reg_rdata_i : '0;
        end
    end

endmodule

//--- verilog/tio_id_ctrl.sv
`timescale 1ns/10ps
module tio_id_ctrl (
    input  logic                                init_clk,
    input  logic                                rst_n_i,
    // Register strobe port
    input  logic                                reg_sel_i,
    input  logic                                reg_we_i,
    input  logic [turfio_pkg::reg_bits-1:0]     reg_index_i,
    input  logic [turfio_pkg::data_bits-1:0]    reg_wdata_i,
    output logic [turfio_pkg::data_bits-1:0]    reg_rdata_o,
    // Board status inputs
    input  logic                                i2c_rdy_i,
    input  logic [1:0]                          conf_i,
    // Control outputs
    output logic                                hsk_local_o,
    output logic                                cratebridge_en_o,
    output logic                                enable_crate_o,
    output logic                                enable_3v3_o
);

    logic [turfio_pkg::ctrl_bits-1:0]   ctrl_q;
    logic [turfio_pkg::data_bits-1:0]   scratch_q;
    logic                               wr_en;

    assign wr_en = reg_sel_i && reg_we_i;

    ////////////////////////////////////////////////////////////////////////////
    // Writable registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            // Crate and 3V3 off, UART routed to TURF
            ctrl_q <= '0;
            scratch_q <= '0;
        end else if (wr_en) begin
            case (reg_index_i)
                turfio_pkg::reg_ctrl: begin
                    // Upper bits dropped
                    ctrl_q <= reg_wdata_i[turfio_pkg::ctrl_bits-1:0];
                end
                turfio_pkg::reg_scratch: begin
                    scratch_q <= reg_wdata_i;
                end
                default: begin
                    // Read-only or unused index
                end
            endcase
        end
    end

    // Control bits straight out of the register
    assign hsk_local_o = ctrl_q[turfio_pkg::ctrl_hsk_local_bit];
    assign cratebridge_en_o = ctrl_q[turfio_pkg::ctrl_cratebridge_bit];
    assign enable_crate_o = ctrl_q[turfio_pkg::ctrl_enable_crate_bit];
    assign enable_3v3_o = ctrl_q[turfio_pkg::ctrl_enable_3v3_bit];

    ////////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        reg_rdata_o = '0;
        case (reg_index_i)
            turfio_pkg::reg_ident: begin
                reg_rdata_o = turfio_pkg::ident_value;
            end
            turfio_pkg::reg_version: begin
                reg_rdata_o = turfio_pkg::date_version;
            end
            turfio_pkg::reg_ctrl: begin
                reg_rdata_o[turfio_pkg::ctrl_bits-1:0] = ctrl_q;
            end
            turfio_pkg::reg_status: begin
                // I2C ready and crate config, live
                reg_rdata_o[turfio_pkg::status_rdy_bit] = i2c_rdy_i;
                reg_rdata_o[turfio_pkg::status_conf_lsb +: 2] = conf_i;
            end
            turfio_pkg::reg_scratch: begin
                reg_rdata_o = scratch_q;
            end
            default: begin
                // Unused index reads zero
                reg_rdata_o = '0;
            end
        endcase
    end

endmodule

//--- common/turfio_pkg.sv
package turfio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Host address fields
    ////////////////////////////////////////////////////////////////////////////

    // Full host address width
    localparam int unsigned addr_bits = 25;
    // Space select, 0 is TURFIO and 1 to 7 are SURFs
    localparam int unsigned space_lsb = 22;
    localparam int unsigned space_bits = 3;
    // Module select inside the TURFIO space
    localparam int unsigned module_lsb = 12;
    localparam int unsigned module_bits = 10;
    // Word register index inside a module
    localparam int unsigned reg_lsb = 2;
    localparam int unsigned reg_bits = 10;

    ////////////////////////////////////////////////////////////////////////////
    // Register map of module 0
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned data_bits = 32;

    localparam logic [reg_bits-1:0] reg_ident = reg_bits'(0);
    localparam logic [reg_bits-1:0] reg_version = reg_bits'(1);
    localparam logic [reg_bits-1:0] reg_ctrl = reg_bits'(2);
    localparam logic [reg_bits-1:0] reg_status = reg_bits'(3);
    localparam logic [reg_bits-1:0] reg_scratch = reg_bits'(4);

    // Control register layout
    localparam int unsigned ctrl_bits = 4;
    localparam int unsigned ctrl_hsk_local_bit = 0;
    localparam int unsigned ctrl_cratebridge_bit = 1;
    localparam int unsigned ctrl_enable_crate_bit = 2;
    localparam int unsigned ctrl_enable_3v3_bit = 3;

    // Status register layout
    localparam int unsigned status_rdy_bit = 0;
    localparam int unsigned status_conf_lsb = 1;

    // Identification word, ASCII "TFIO"
    localparam logic [data_bits-1:0] ident_value = "TFIO";

    // Firmware version fields
    localparam logic [15:0] fw_date = 16'h0000;
    localparam logic [3:0] ver_major = 4'd0;
    localparam logic [3:0] ver_minor = 4'd4;
    localparam logic [7:0] ver_rev = 8'd0;
    localparam logic [data_bits-1:0] date_version = {fw_date, ver_major, ver_minor, ver_rev};

    ////////////////////////////////////////////////////////////////////////////
    // Crate UART retiming
    ////////////////////////////////////////////////////////////////////////////

    // 160 clocks per bit, sampled late to ride out the slow open-drain rise
    localparam int unsigned uart_baud_period = 160;
    localparam int unsigned uart_sample_point = 120;
    // Start, 8 data, stop
    localparam int unsigned uart_frame_bits = 10;

    localparam int unsigned uart_cnt_bits = $clog2(uart_baud_period);
    localparam int unsigned uart_bit_bits = $clog2(uart_frame_bits);
    localparam logic [uart_cnt_bits-1:0] uart_period_last = uart_cnt_bits'(uart_baud_period - 1);
    localparam logic [uart_cnt_bits-1:0] uart_sample_cnt = uart_cnt_bits'(uart_sample_point - 1);
    localparam logic [uart_bit_bits-1:0] uart_last_bit = uart_bit_bits'(uart_frame_bits - 1);

endpackage
